//--- all.f
rtl/sp_host_pkg.sv
rtl/sp_pool_pkg.sv
rtl/sp_param_if.sv
rtl/trig_param_decode.sv
rtl/wave_buffer.sv
rtl/neuron_pool_exec.sv
rtl/spike_tally.sv
rtl/size_principle_top.sv
dv/size_principle_properties.sv
dv/tb_size_principle.sv

//--- Makefile
# Verilator build and run of the size principle testbench
TOP := tb_size_principle

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- dv/tb_size_principle.sv
`timescale 1ns/1ps

module tb_size_principle;

    localparam int NN         = sp_pool_pkg::NN;
    // cycles allowed per wait
    localparam int WAIT_LIMIT = 2000;

    logic                             ep50trig;
    logic                             reset_global;
    logic                             reset_sim;
    logic [sp_host_pkg::TRIG_W-1:0]   trig;
    logic [sp_host_pkg::WIRE_W-1:0]   wire_data;
    logic                             pipe_write;
    logic [sp_pool_pkg::SAMPLE_W-1:0] pipe_data;
    logic                             spike;
    logic [sp_pool_pkg::ID_W-1:0]     spike_id;
    logic [sp_pool_pkg::SAMPLE_W-1:0] drive;
    logic [sp_pool_pkg::CNT_W-1:0]    spike_count;
    logic                             count_valid;

    int          errors;
    int          checks;
    // set once a wait runs out
    // later waits return at once
    bit          hung;
    logic [31:0] lfsr;

    // reference copy of the parameters
    int unsigned m_half;
    logic [15:0] m_gain;
    logic [31:0] m_thr;
    logic [31:0] m_step;
    logic [4:0]  m_leak;
    // reference membranes
    logic [31:0] m_v [NN];

    // waveform as piped in
    logic [15:0] wave [$];
    int          seen_ids [$];
    int          model_ids [$];
    int          fire_cnt [NN];

    size_principle_top dut (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_reset_sim    (reset_sim),
        .i_trig         (trig),
        .i_wire_data    (wire_data),
        .i_pipe_write   (pipe_write),
        .i_pipe_data    (pipe_data),
        .o_spike        (spike),
        .o_spike_id     (spike_id),
        .o_drive        (drive),
        .o_spike_count  (spike_count),
        .o_count_valid  (count_valid)
    );

    // 100 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever #50 ep50trig = ~ep50trig;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    // one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_interval(input int n_cyc);
        checks++;
        if (n_cyc != NN * (m_half + 1))
        begin
            errors++;
            $display("o_count_valid pulses came %0d cycles apart instead of %0d",
                     n_cyc, NN * (m_half + 1));
        end
    endtask

    // step one falling edge at a time until o_count_valid
    // spike ids seen on the way are kept
    task automatic wait_valid(output int n_cyc);
        n_cyc = 0;
        seen_ids.delete();
        if (hung)
            return;
        do
        begin
            @(negedge ep50trig);
            n_cyc++;
            if (spike && !count_valid)
                seen_ids.push_back(int'(spike_id));
        end
        while (!count_valid && n_cyc < WAIT_LIMIT);
        if (!count_valid)
        begin
            errors++;
            hung = 1'b1;
            $display("o_count_valid did not pulse within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // pulse one trigger bit and update the model copy
    task automatic load_param(input int bit_pos, input logic [31:0] value);
        @(negedge ep50trig);
        trig[bit_pos] = 1'b1;
        wire_data     = value;
        @(negedge ep50trig);
        trig = '0;
        case (bit_pos)
            sp_host_pkg::TRIG_HALF_CNT:   m_half = value[15:0];
            sp_host_pkg::TRIG_THRESHOLD:  m_thr  = value;
            sp_host_pkg::TRIG_THR_STEP:   m_step = value;
            sp_host_pkg::TRIG_LEAK_SHIFT: m_leak = value[4:0];
            sp_host_pkg::TRIG_GAIN:       m_gain = value[15:0];
            default: ;
        endcase
    endtask

    task automatic pulse_reset_sim();
        @(negedge ep50trig);
        reset_sim = 1'b1;
        @(negedge ep50trig);
        reset_sim = 1'b0;
        foreach (m_v[i])
            m_v[i] = '0;
    endtask

    // write the whole wave then restart the simulation
    task automatic pipe_wave();
        foreach (wave[k])
        begin
            @(negedge ep50trig);
            pipe_write = 1'b1;
            pipe_data  = wave[k];
        end
        @(negedge ep50trig);
        pipe_write = 1'b0;
        pulse_reset_sim();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // leak then saturating drive then fire against the growing threshold
    task automatic model_period(input logic [15:0] s, output int n_fire);
        logic [63:0] v;
        logic [63:0] thr;
        n_fire = 0;
        model_ids.delete();
        for (int i = 0; i < NN; i++)
        begin
            v = {32'd0, m_v[i]};
            v = v - (v >> m_leak);
            v = v + 64'(s) * 64'(m_gain);
            if (v > 64'h0000_0000_ffff_ffff)
                v = 64'h0000_0000_ffff_ffff;
            thr = 64'(m_thr) + 64'(i) * 64'(m_step);
            if (v >= thr)
            begin
                n_fire++;
                model_ids.push_back(i);
                m_v[i] = '0;
            end
            else
                m_v[i] = v[31:0];
        end
    endtask

    // periods from the model state starting right after a sim reset
    task automatic run_model(input int n_per);
        int n_cyc;
        int n_exp;
        for (int p = 0; p < n_per; p++)
        begin
            model_period(wave[p % wave.size()], n_exp);
            wait_valid(n_cyc);
            if (hung)
                return;
            check_val("o_spike_count", spike_count, n_exp);
            checks++;
            if (seen_ids.size() != model_ids.size())
            begin
                errors++;
                $display("pool fired %0d times in period %0d, model fired %0d",
                         seen_ids.size(), p, model_ids.size());
            end
            for (int k = 0; k < seen_ids.size() && k < model_ids.size(); k++)
                check_val("o_spike_id", seen_ids[k], model_ids[k]);
            foreach (seen_ids[k])
                fire_cnt[seen_ids[k]]++;
            // first period starts mid divider count
            if (p > 0)
                check_interval(n_cyc);
            // read pointer already moved on
            check_val("o_drive", drive, wave[(p + 1) % wave.size()]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int n_cyc;
        int n_spikes;
        check_val("o_drive", drive, 16'h0);
        wait_valid(n_cyc);
        n_spikes = seen_ids.size();
        for (int p = 0; p < 3; p++)
        begin
            wait_valid(n_cyc);
            n_spikes += seen_ids.size();
            check_val("o_spike_count", spike_count, 32'h0);
            check_interval(n_cyc);
        end
        checks++;
        if (n_spikes != 0)
        begin
            errors++;
            $display("o_spike rose %0d times with no waveform loaded", n_spikes);
        end
    endtask

    task automatic test_param_load();
        int n_cyc;
        load_param(sp_host_pkg::TRIG_HALF_CNT, 32'd1);
        // let the divider settle on the new compare
        wait_valid(n_cyc);
        wait_valid(n_cyc);
        for (int p = 0; p < 3; p++)
        begin
            wait_valid(n_cyc);
            check_interval(n_cyc);
        end
    endtask

    task automatic test_playback();
        wave.delete();
        for (int k = 0; k < 5; k++)
            wave.push_back(rand_bits(16));
        pipe_wave();
        check_val("o_drive", drive, wave[0]);
        // seven periods to see the wrap
        run_model(7);
    endtask

    task automatic test_recruitment();
        load_param(sp_host_pkg::TRIG_GAIN, 32'd3);
        load_param(sp_host_pkg::TRIG_THRESHOLD, 32'd900);
        load_param(sp_host_pkg::TRIG_THR_STEP, 32'd150);
        load_param(sp_host_pkg::TRIG_LEAK_SHIFT, 32'd3);
        wave.delete();
        for (int k = 0; k < 5; k++)
            wave.push_back(16'd100);
        pipe_wave();
        foreach (fire_cnt[i])
            fire_cnt[i] = 0;
        run_model(10);
        checks++;
        if (fire_cnt[0] == 0)
        begin
            errors++;
            $display("neuron 0 never fired under constant drive");
        end
        // small units recruited at least as often as big ones
        for (int i = 1; i < NN; i++)
        begin
            checks++;
            if (fire_cnt[i] > fire_cnt[i - 1])
            begin
                errors++;
                $display("neuron %0d fired %0d times, more than neuron %0d with %0d",
                         i, fire_cnt[i], i - 1, fire_cnt[i - 1]);
            end
        end
    endtask

    task automatic test_sim_reset();
        wave.delete();
        for (int k = 0; k < 5; k++)
            wave.push_back(rand_bits(9));
        pipe_wave();
        run_model(3);
        // land inside a period
        repeat (5) @(negedge ep50trig);
        pulse_reset_sim();
        check_val("o_drive", drive, wave[0]);
        // counts still follow the parameters loaded earlier
        run_model(5);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        reset_sim    = 1'b0;
        trig         = '0;
        wire_data    = '0;
        pipe_write   = 1'b0;
        pipe_data    = '0;
        errors       = 0;
        checks       = 0;
        hung         = 1'b0;
        lfsr         = 32'h01cdc946;
        // parameter values after global reset
        m_half       = 3;
        m_gain       = 16'd1;
        m_thr        = 32'd1000;
        m_step       = 32'd100;
        m_leak       = 5'd4;
        foreach (m_v[i])
            m_v[i] = '0;
        repeat (3) @(negedge ep50trig);
        reset_global = 1'b0;

        test_reset_state();
        test_param_load();
        test_playback();
        test_recruitment();
        test_sim_reset();

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/size_principle_properties.sv
`timescale 1ns/1ps

// timing checks on the pool and tally pulses
module size_principle_properties #(
    parameter bit CHECK_VALID = 1'b0
) (
    input logic                         i_clk,
    input logic                         i_rst,
    input logic                         i_period_end,
    input logic                         i_spike,
    input logic [sp_pool_pkg::ID_W-1:0] i_spike_id,
    input logic                         i_count_valid
);

    // period end lasts a single cycle
    a_period_end_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        i_period_end |=> !i_period_end)
        else $error("period end stayed high for more than one cycle");

    // pool side only
    if (!CHECK_VALID)
    begin : g_id
        // spike id names a real neuron
        a_spike_id_range: assert property (@(posedge i_clk) disable iff (i_rst)
            i_spike |-> (i_spike_id < sp_pool_pkg::NN))
            else $error("spike id out of range of the pool");
    end

    // tally side only
    if (CHECK_VALID)
    begin : g_valid
        a_valid_after_end: assert property (@(posedge i_clk) disable iff (i_rst)
            i_period_end |=> i_count_valid)
            else $error("count valid missing one cycle after period end");
        a_valid_needs_end: assert property (@(posedge i_clk) disable iff (i_rst)
            i_count_valid |-> $past(i_period_end))
            else $error("count valid without a period end one cycle before");
    end

endmodule

// pool outputs without count valid
bind neuron_pool_exec size_principle_properties #(.CHECK_VALID(1'b0)) u_pool_props (
    .i_clk         (i_ep50trig),
    .i_rst         (i_reset_global || i_reset_sim),
    .i_period_end  (o_period_end),
    .i_spike       (o_spike),
    .i_spike_id    (o_spike_id),
    .i_count_valid (1'b0)
);

// tally side has no spike id
bind spike_tally size_principle_properties #(.CHECK_VALID(1'b1)) u_tally_props (
    .i_clk         (i_ep50trig),
    .i_rst         (i_reset_global || i_reset_sim),
    .i_period_end  (i_period_end),
    .i_spike       (i_spike),
    .i_spike_id    ('0),
    .i_count_valid (o_count_valid)
);

//--- rtl/size_principle_top.sv
`timescale 1ns/1ps

module size_principle_top (
    input  logic                             i_ep50trig,
    input  logic                             i_reset_global,
    input  logic                             i_reset_sim,
    input  logic [sp_host_pkg::TRIG_W-1:0]   i_trig,
    input  logic [sp_host_pkg::WIRE_W-1:0]   i_wire_data,
    input  logic                             i_pipe_write,
    input  logic [sp_pool_pkg::SAMPLE_W-1:0] i_pipe_data,
    output logic                             o_spike,
    output logic [sp_pool_pkg::ID_W-1:0]     o_spike_id,
    output logic [sp_pool_pkg::SAMPLE_W-1:0] o_drive,
    output logic [sp_pool_pkg::CNT_W-1:0]    o_spike_count,
    output logic                             o_count_valid
);

    // live parameters
    sp_param_if param_bus ();

    logic [sp_pool_pkg::SAMPLE_W-1:0] sample;
    logic                             period_end;
    logic                             spike;

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, result
    ////////////////////////////////////////////////////////////////////////////

    trig_param_decode u_decode (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_trig         (i_trig),
        .i_wire_data    (i_wire_data),
        .param          (param_bus.src)
    );

    // waveform playback into the pool
    wave_buffer u_wave (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_reset_sim    (i_reset_sim),
        .i_pipe_write   (i_pipe_write),
        .i_pipe_data    (i_pipe_data),
        .i_period_end   (period_end),
        .o_sample       (sample)
    );

    neuron_pool_exec u_pool (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_reset_sim    (i_reset_sim),
        .param          (param_bus.dst),
        .i_sample       (sample),
        .o_spike        (spike),
        .o_spike_id     (o_spike_id),
        .o_period_end   (period_end)
    );

    spike_tally u_tally (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_reset_sim    (i_reset_sim),
        .i_spike        (spike),
        .i_period_end   (period_end),
        .o_spike_count  (o_spike_count),
        .o_count_valid  (o_count_valid)
    );

    assign o_spike = spike;
    assign o_drive = sample;

endmodule

//--- rtl/spike_tally.sv
`timescale 1ns/1ps

module spike_tally (
    input  logic                          i_ep50trig,
    input  logic                          i_reset_global,
    input  logic                          i_reset_sim,
    input  logic                          i_spike,
    input  logic                          i_period_end,
    output logic [sp_pool_pkg::CNT_W-1:0] o_spike_count,
    output logic                          o_count_valid
);

    // running count for the open period
    logic [sp_pool_pkg::CNT_W-1:0] cnt;
    // count including this cycle's spike
    logic [sp_pool_pkg::CNT_W-1:0] cnt_next;

    assign cnt_next = cnt + {{(sp_pool_pkg::CNT_W - 1){1'b0}}, i_spike};

    ////////////////////////////////////////////////////////////////////////////
    // per period spike count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_reset_sim)
        begin
            cnt           <= '0;
            o_spike_count <= '0;
            o_count_valid <= 1'b0;
        end
        else if (i_period_end)
        begin
            // spike coinciding with period end belongs to the closing period
            o_spike_count <= cnt_next;
            o_count_valid <= 1'b1;
            cnt           <= '0;
        end
        else
        begin
            cnt           <= cnt_next;
            o_count_valid <= 1'b0;
        end
    end

endmodule

//--- rtl/neuron_pool_exec.sv
`timescale 1ns/1ps

module neuron_pool_exec (
    input  logic                             i_ep50trig,
    input  logic                             i_reset_global,
    input  logic                             i_reset_sim,
    sp_param_if.dst                          param,
    input  logic [sp_pool_pkg::SAMPLE_W-1:0] i_sample,
    output logic                             o_spike,
    output logic [sp_pool_pkg::ID_W-1:0]     o_spike_id,
    output logic                             o_period_end
);

    // scheduler state
    sp_pool_pkg::sched_phase_e              phase;
    logic [sp_host_pkg::HALF_CNT_W-1:0]     div_cnt;
    logic                                   div_wrap;
    logic [sp_pool_pkg::ID_W-1:0]           idx;
    logic                                   idx_last;

    // membranes, one per neuron
    logic [sp_pool_pkg::V_W-1:0]            v_mem [sp_pool_pkg::NN];

    // step datapath
    logic [sp_pool_pkg::V_W-1:0]            v_cur;
    logic [sp_pool_pkg::V_W-1:0]            v_leak;
    logic [sp_pool_pkg::V_W-1:0]            drive;
    logic [sp_pool_pkg::V_W:0]              v_sum;
    logic [sp_pool_pkg::V_W-1:0]            v_int;
    logic [sp_pool_pkg::THR_EXT_W-1:0]      thr_ext;
    logic                                   fire;

    ////////////////////////////////////////////////////////////////////////////
    // tick divider
    ////////////////////////////////////////////////////////////////////////////

    // greater-or-equal so a smaller half_cnt mid-run still wraps
    assign div_wrap = (div_cnt >= param.half_cnt);
    assign idx_last = (idx == sp_pool_pkg::ID_W'(sp_pool_pkg::NN - 1));

    ////////////////////////////////////////////////////////////////////////////
    // leaky integrate and fire for the current index
    ////////////////////////////////////////////////////////////////////////////

    assign v_cur  = v_mem[idx];
    // leak first
    assign v_leak = v_cur - (v_cur >> param.leak_shift);
    // 16 by 16 product fits the membrane width
    assign drive  = {{(sp_pool_pkg::V_W - sp_pool_pkg::SAMPLE_W){1'b0}}, i_sample}
                  * {{(sp_pool_pkg::V_W - sp_host_pkg::GAIN_W){1'b0}}, param.gain};
    assign v_sum  = {1'b0, v_leak} + {1'b0, drive};
    // clamp on carry out
    assign v_int  = v_sum[sp_pool_pkg::V_W] ? '1 : v_sum[sp_pool_pkg::V_W-1:0];

    // threshold grows with index, size principle
    assign thr_ext =
        {{(sp_pool_pkg::THR_EXT_W - sp_host_pkg::THR_W){1'b0}}, param.threshold}
        + {{(sp_pool_pkg::THR_EXT_W - sp_pool_pkg::ID_W){1'b0}}, idx}
        * {{(sp_pool_pkg::THR_EXT_W - sp_host_pkg::THR_W){1'b0}}, param.thr_step};

    assign fire = ({{(sp_pool_pkg::THR_EXT_W - sp_pool_pkg::V_W){1'b0}}, v_int} >= thr_ext);

    ////////////////////////////////////////////////////////////////////////////
    // phase machine and state update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global || i_reset_sim)
        begin
            phase        <= sp_pool_pkg::PHASE_WAIT;
            div_cnt      <= '0;
            idx          <= '0;
            o_spike      <= 1'b0;
            o_spike_id   <= '0;
            o_period_end <= 1'b0;
            for (int n = 0; n < sp_pool_pkg::NN; n++)
                v_mem[n] <= '0;
        end
        else
        begin
            // divider free runs, wrap schedules the next step
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            phase   <= div_wrap ? sp_pool_pkg::PHASE_STEP : sp_pool_pkg::PHASE_WAIT;

            // pulses default low
            o_spike      <= 1'b0;
            o_period_end <= 1'b0;

            if (phase == sp_pool_pkg::PHASE_STEP)
            begin
                // fired neuron restarts from rest
                v_mem[idx]   <= fire ? '0 : v_int;
                o_spike      <= fire;
                o_spike_id   <= idx;
                // last neuron closes the period
                o_period_end <= idx_last;
                idx          <= idx_last ? '0 : idx + 1'b1;
            end
        end
    end

endmodule

//--- rtl/wave_buffer.sv
`timescale 1ns/1ps

module wave_buffer (
    input  logic                             i_ep50trig,
    input  logic                             i_reset_global,
    input  logic                             i_reset_sim,
    input  logic                             i_pipe_write,
    input  logic [sp_pool_pkg::SAMPLE_W-1:0] i_pipe_data,
    input  logic                             i_period_end,
    output logic [sp_pool_pkg::SAMPLE_W-1:0] o_sample
);

    // sample store
    logic [sp_pool_pkg::SAMPLE_W-1:0] mem [sp_pool_pkg::WAVE_DEPTH];

    // write pointer carries one extra bit
    // top bit set means the buffer is full
    logic [sp_pool_pkg::WAVE_AW:0]   wr_ptr;
    // highest fill level seen, sets the loop length
    logic [sp_pool_pkg::WAVE_AW:0]   n_samples;
    logic [sp_pool_pkg::WAVE_AW-1:0] rd_ptr;
    logic                            wr_ok;
    logic [sp_pool_pkg::WAVE_AW:0]   wr_ptr_inc;

    // depth is a power of two
    assign wr_ok      = i_pipe_write && !wr_ptr[sp_pool_pkg::WAVE_AW];
    assign wr_ptr_inc = wr_ptr + 1'b1;

    // pipe writes into memory
    always_ff @(posedge i_ep50trig)
    begin
        if (wr_ok)
            mem[wr_ptr[sp_pool_pkg::WAVE_AW-1:0]] <= i_pipe_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            n_samples <= '0;
        end
        else if (i_reset_sim)
        begin
            // restart playback, loaded samples stay
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_ok)
            begin
                wr_ptr <= wr_ptr_inc;
                if (wr_ptr_inc > n_samples)
                    n_samples <= wr_ptr_inc;
            end
            // one sample per simulation period, looping
            if (i_period_end)
            begin
                if ({1'b0, rd_ptr} + 1'b1 >= n_samples)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // empty buffer drives zero
    assign o_sample = (n_samples == '0) ? '0 : mem[rd_ptr];

endmodule

//--- rtl/trig_param_decode.sv
`timescale 1ns/1ps

module trig_param_decode (
    input  logic                           i_ep50trig,
    input  logic                           i_reset_global,
    input  logic [sp_host_pkg::TRIG_W-1:0] i_trig,
    input  logic [sp_host_pkg::WIRE_W-1:0] i_wire_data,
    sp_param_if.src                        param
);

    ////////////////////////////////////////////////////////////////////////////
    // trigger loaded parameter registers
    ////////////////////////////////////////////////////////////////////////////

    // one register per trigger bit
    // a bit high at the edge loads the wire word at that edge
    // several bits at once all take the same word
    always_ff @(posedge i_ep50trig)
    begin
        if (i_reset_global)
        begin
            param.half_cnt   <= sp_host_pkg::DEF_HALF_CNT;
            param.gain       <= sp_host_pkg::DEF_GAIN;
            param.threshold  <= sp_host_pkg::DEF_THRESHOLD;
            param.thr_step   <= sp_host_pkg::DEF_THR_STEP;
            param.leak_shift <= sp_host_pkg::DEF_LEAK_SHIFT;
        end
        else
        begin
            // divider compare, low half of the word
            if (i_trig[sp_host_pkg::TRIG_HALF_CNT])
                param.half_cnt <= i_wire_data[sp_host_pkg::HALF_CNT_W-1:0];
            // full word thresholds
            if (i_trig[sp_host_pkg::TRIG_THRESHOLD])
                param.threshold <= i_wire_data[sp_host_pkg::THR_W-1:0];
            if (i_trig[sp_host_pkg::TRIG_THR_STEP])
                param.thr_step <= i_wire_data[sp_host_pkg::THR_W-1:0];
            // shift amount, low bits only
            if (i_trig[sp_host_pkg::TRIG_LEAK_SHIFT])
                param.leak_shift <= i_wire_data[sp_host_pkg::LEAK_W-1:0];
            // current gain
            if (i_trig[sp_host_pkg::TRIG_GAIN])
                param.gain <= i_wire_data[sp_host_pkg::GAIN_W-1:0];
            // other trigger bits fall through untouched
        end
    end

endmodule

//--- rtl/sp_param_if.sv
`timescale 1ns/1ps

// live parameter set, decoder to pool
interface sp_param_if;

    // tick divider compare value
    logic [sp_host_pkg::HALF_CNT_W-1:0] half_cnt;
    // sample multiplier
    logic [sp_host_pkg::GAIN_W-1:0]     gain;
    // threshold of neuron 0
    logic [sp_host_pkg::THR_W-1:0]      threshold;
    // added per neuron index
    logic [sp_host_pkg::THR_W-1:0]      thr_step;
    // membrane decay as a right shift
    logic [sp_host_pkg::LEAK_W-1:0]     leak_shift;

    // register side
    modport src (
        output half_cnt,
        output gain,
        output threshold,
        output thr_step,
        output leak_shift
    );

    // consumer side
    modport dst (
        input half_cnt,
        input gain,
        input threshold,
        input thr_step,
        input leak_shift
    );

endinterface

//--- rtl/sp_pool_pkg.sv
package sp_pool_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // neuron pool geometry
    ////////////////////////////////////////////////////////////////////////////

    // neurons in the pool, ordered small to big
    localparam int NN       = 8;
    // spike id width, covers 0 .. NN-1
    localparam int ID_W     = 3;
    // unsigned membrane state
    localparam int V_W      = 32;
    // threshold compare width
    // room for threshold plus index times step without overflow
    localparam int THR_EXT_W = V_W + ID_W + 1;

    // waveform playback
    localparam int SAMPLE_W   = 16;
    localparam int WAVE_DEPTH = 256;
    localparam int WAVE_AW    = $clog2(WAVE_DEPTH);

    // spike tally width
    localparam int CNT_W = 32;

    // scheduler phases
    typedef enum logic [0:0] {
        PHASE_WAIT = 1'b0,
        PHASE_STEP = 1'b1
    } sched_phase_e;

endpackage

//--- rtl/sp_host_pkg.sv
package sp_host_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // host bus widths
    ////////////////////////////////////////////////////////////////////////////

    // trigger bus, one bit per parameter
    localparam int TRIG_W     = 16;
    // parameter data word from the wire bus
    localparam int WIRE_W     = 32;
    // tick divider compare value
    localparam int HALF_CNT_W = 16;
    // input current gain
    localparam int GAIN_W     = 16;
    // base threshold and per-unit threshold step
    localparam int THR_W      = 32;
    // leak shift amount
    localparam int LEAK_W     = 5;

    // trigger bit positions
    // bits 4 and 5 are unused, kept free for later parameters
    typedef enum logic [3:0] {
        TRIG_HALF_CNT   = 4'd0,
        TRIG_THRESHOLD  = 4'd1,
        TRIG_THR_STEP   = 4'd2,
        TRIG_LEAK_SHIFT = 4'd3,
        TRIG_GAIN       = 4'd6
    } trig_idx_e;

    // parameter values after global reset
    localparam logic [HALF_CNT_W-1:0] DEF_HALF_CNT   = 16'd3;
    localparam logic [GAIN_W-1:0]     DEF_GAIN       = 16'd1;
    localparam logic [THR_W-1:0]      DEF_THRESHOLD  = 32'd1000;
    localparam logic [THR_W-1:0]      DEF_THR_STEP   = 32'd100;
    localparam logic [LEAK_W-1:0]     DEF_LEAK_SHIFT = 5'd4;

endpackage
